/* build.f */
+incdir+design
design/bmc_bus_pkg.sv
design/bmc_video_pkg.sv
design/bmc_regs.sv
design/bmc_scan_fetch.sv
design/bmc_pixel_plot.sv
design/bmc_mem_arbiter.sv
design/bmc_pixel_out.sv
design/bitmap_ctrl.sv
verification/tb_clock.sv
verification/bitmap_ctrl_tb.sv

/* design/bitmap_ctrl.sv */
// bitmap display controller top: registers, fetcher, plotter, arbiter and pixel output
`timescale 1ns/1ps
`default_nettype none

module bitmap_ctrl (
	input  wire                          vclk,
	input  wire                          rst_i,
	input  wire                          s_cyc_i,
	input  wire                          s_stb_i,
	input  wire                          s_we_i,
	input  wire bmc_bus_pkg::mem_adr_t   s_adr_i,
	input  wire bmc_bus_pkg::mem_dat_t   s_dat_i,
	output bmc_bus_pkg::mem_dat_t        s_dat_o,
	output logic                         s_ack_o,
	output bmc_bus_pkg::mem_req_t        m_req_o,
	input  wire bmc_bus_pkg::mem_rsp_t   m_rsp_i,
	input  wire                          hsync_i,
	input  wire                          vsync_i,
	input  wire                          blank_i,
	output bmc_video_pkg::rgb_t          rgb_o
);

	// register outputs
	logic onoff;
	bmc_video_pkg::coord_t hdisp;
	bmc_video_pkg::coord_t vdisp;
	bmc_bus_pkg::mem_adr_t base;
	bmc_video_pkg::coord_t px;
	bmc_video_pkg::coord_t py;
	bmc_video_pkg::pixel_t color;
	bmc_video_pkg::rop_t rop;
	logic plot_go;
	logic plot_busy;
	// video side
	logic line_start;
	bmc_video_pkg::coord_t fetch_row;
	bmc_video_pkg::line_wr_t line_wr;
	// memory masters
	bmc_bus_pkg::mem_req_t fetch_req;
	bmc_bus_pkg::mem_rsp_t fetch_rsp;
	bmc_bus_pkg::mem_req_t plot_req;
	bmc_bus_pkg::mem_rsp_t plot_rsp;

	bmc_regs regs_i (
		.vclk(vclk), .rst_i(rst_i),
		.s_cyc_i(s_cyc_i), .s_stb_i(s_stb_i), .s_we_i(s_we_i),
		.s_adr_i(s_adr_i), .s_dat_i(s_dat_i), .s_ack_o(s_ack_o), .s_dat_o(s_dat_o),
		.onoff_o(onoff), .hdisp_o(hdisp), .vdisp_o(vdisp), .base_o(base),
		.px_o(px), .py_o(py), .color_o(color), .rop_o(rop),
		.plot_go_o(plot_go), .plot_busy_i(plot_busy)
	);

	bmc_scan_fetch fetch_i (
		.vclk(vclk), .rst_i(rst_i),
		.line_start_i(line_start), .fetch_row_i(fetch_row), .onoff_i(onoff),
		.hdisp_i(hdisp), .vdisp_i(vdisp), .base_i(base),
		.mem_req_o(fetch_req), .mem_rsp_i(fetch_rsp), .line_wr_o(line_wr)
	);

	bmc_pixel_plot plot_i (
		.vclk(vclk), .rst_i(rst_i),
		.plot_go_i(plot_go), .px_i(px), .py_i(py), .hdisp_i(hdisp), .base_i(base),
		.color_i(color), .rop_i(rop), .busy_o(plot_busy),
		.mem_req_o(plot_req), .mem_rsp_i(plot_rsp)
	);

	bmc_mem_arbiter arb_i (
		.vclk(vclk), .rst_i(rst_i),
		.fetch_req_i(fetch_req), .fetch_rsp_o(fetch_rsp),
		.plot_req_i(plot_req), .plot_rsp_o(plot_rsp),
		.mem_req_o(m_req_o), .mem_rsp_i(m_rsp_i)
	);

	bmc_pixel_out pixel_out_i (
		.vclk(vclk), .rst_i(rst_i),
		.hsync_i(hsync_i), .vsync_i(vsync_i), .blank_i(blank_i), .onoff_i(onoff),
		.hdisp_i(hdisp), .vdisp_i(vdisp), .line_wr_i(line_wr),
		.line_start_o(line_start), .fetch_row_o(fetch_row), .rgb_o(rgb_o)
	);

endmodule

`default_nettype wire

/* design/bmc_bus_pkg.sv */
// memory bus address and data types, wishbone request and response structs
`default_nettype none
`include "bmc_defs.svh"

package bmc_bus_pkg;

	// byte address, data word and byte lane select
	typedef logic [`BMC_ADR_W-1:0] mem_adr_t;
	typedef logic [`BMC_DAT_W-1:0] mem_dat_t;
	typedef logic [`BMC_DAT_W/8-1:0] mem_sel_t;

	// master side of a classic wishbone cycle
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		mem_sel_t sel;
		mem_adr_t adr;
		mem_dat_t dat;
	} mem_req_t;

	// memory side, ack plus read data
	typedef struct packed {
		logic     ack;
		mem_dat_t dat;
	} mem_rsp_t;

endpackage

`default_nettype wire

/* design/bmc_defs.svh */
// register offsets, bus widths, reset values and line buffer depth
`ifndef BMC_DEFS_SVH
`define BMC_DEFS_SVH

// ====================================================================
// register word offsets, decoded from s_adr_i[4:2]
// ====================================================================
`define BMC_REG_CTRL    3'd0
`define BMC_REG_HDISP   3'd1
`define BMC_REG_VDISP   3'd2
`define BMC_REG_BASE    3'd3
`define BMC_REG_PX      3'd4
`define BMC_REG_PY      3'd5
`define BMC_REG_COLOR   3'd6
`define BMC_REG_PCMD    3'd7

// bus and coordinate widths
`define BMC_ADR_W       32
`define BMC_DAT_W       32
`define BMC_COORD_W     12

// line buffer depth in 32-bit words, two pixels per word
`define BMC_LINE_WORDS  512

// register reset values
`define BMC_BASE_RESET  32'h0020_0000
`define BMC_HDISP_RESET 12'd320
`define BMC_VDISP_RESET 12'd240

`endif

/* design/bmc_mem_arbiter.sv */
// fixed-priority non-preemptive arbiter, fetcher and plotter onto one memory port
`timescale 1ns/1ps
`default_nettype none

module bmc_mem_arbiter (
	input  wire                          vclk,
	input  wire                          rst_i,
	input  wire bmc_bus_pkg::mem_req_t   fetch_req_i,
	output bmc_bus_pkg::mem_rsp_t        fetch_rsp_o,
	input  wire bmc_bus_pkg::mem_req_t   plot_req_i,
	output bmc_bus_pkg::mem_rsp_t        plot_rsp_o,
	output bmc_bus_pkg::mem_req_t        mem_req_o,
	input  wire bmc_bus_pkg::mem_rsp_t   mem_rsp_i
);

	// owner 1 means the plotter holds the bus
	logic owner_q;
	logic locked_q;
	logic gnt_plot;

	// a locked cycle keeps its owner, otherwise the fetcher wins
	always_comb begin
		if (locked_q)
			gnt_plot = owner_q;
		else if (fetch_req_i.cyc)
			gnt_plot = 1'b0;
		else if (plot_req_i.cyc)
			gnt_plot = 1'b1;
		else
			gnt_plot = owner_q;
	end

	assign mem_req_o = gnt_plot ? plot_req_i : fetch_req_i;

	// ack only to the granted master, the other one just waits
	always_comb begin
		fetch_rsp_o.ack = mem_rsp_i.ack & ~gnt_plot;
		fetch_rsp_o.dat = mem_rsp_i.dat;
		plot_rsp_o.ack = mem_rsp_i.ack & gnt_plot;
		plot_rsp_o.dat = mem_rsp_i.dat;
	end

	// lock from cyc rising until the cycle after ack
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			owner_q <= 1'b0;
			locked_q <= 1'b0;
		end else begin
			owner_q <= gnt_plot;
			locked_q <= mem_req_o.cyc & ~mem_rsp_i.ack;
		end
	end

endmodule

`default_nettype wire

/* design/bmc_pixel_out.sv */
// pixel output: sync edges, row and column counters, line buffer, rgb565 expansion
`timescale 1ns/1ps
`default_nettype none
`include "bmc_defs.svh"

module bmc_pixel_out (
	input  wire                           vclk,
	input  wire                           rst_i,
	input  wire                           hsync_i,
	input  wire                           vsync_i,
	input  wire                           blank_i,
	input  wire                           onoff_i,
	input  wire bmc_video_pkg::coord_t    hdisp_i,
	input  wire bmc_video_pkg::coord_t    vdisp_i,
	input  wire bmc_video_pkg::line_wr_t  line_wr_i,
	output logic                          line_start_o,
	output bmc_video_pkg::coord_t         fetch_row_o,
	output bmc_video_pkg::rgb_t           rgb_o
);

	logic hsync_q;
	logic vsync_q;
	logic vs_rise;
	bmc_video_pkg::coord_t row_q;
	bmc_video_pkg::coord_t disp_row_q;
	bmc_video_pkg::coord_t col_q;
	bmc_bus_pkg::mem_dat_t line_buf [0:`BMC_LINE_WORDS-1];
	bmc_bus_pkg::mem_dat_t rd_word_q;
	logic hsel_q;
	logic vis_q;
	bmc_video_pkg::pixel_t pix;

	assign line_start_o = hsync_i & ~hsync_q;
	assign vs_rise = vsync_i & ~vsync_q;
	// row handed to the fetcher on this hsync
	assign fetch_row_o = row_q;
	assign pix = hsel_q ? rd_word_q[31:16] : rd_word_q[15:0];

	// ====================================================================
	// counters, visibility and output register
	// ====================================================================
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
			row_q <= '0;
			disp_row_q <= '0;
			col_q <= '0;
			vis_q <= 1'b0;
			rgb_o <= '0;
		end else begin
			hsync_q <= hsync_i;
			vsync_q <= vsync_i;
			if (line_start_o)
				disp_row_q <= row_q;
			if (vs_rise)
				row_q <= '0;
			else if (line_start_o)
				row_q <= row_q + 12'd1;
			// column 0 is the first active cycle after hsync
			if (line_start_o)
				col_q <= '0;
			else if (!blank_i)
				col_q <= col_q + 12'd1;
			vis_q <= onoff_i && !blank_i && (disp_row_q < vdisp_i) && (col_q < hdisp_i);
			// 565 fields at the top of each byte
			rgb_o <= vis_q ? {pix[15:11], 3'b000, pix[10:5], 2'b00, pix[4:0], 3'b000} : '0;
		end
	end

	// line buffer, written by the fetcher and read by column
	always_ff @(posedge vclk) begin
		if (line_wr_i.we)
			line_buf[line_wr_i.idx] <= line_wr_i.dat;
		rd_word_q <= line_buf[bmc_video_pkg::line_idx_t'(col_q >> 1)];
		hsel_q <= col_q[0];
	end

endmodule

`default_nettype wire

/* design/bmc_pixel_plot.sv */
// pixel plotter: read-modify-write of one rgb565 pixel with a raster op
`timescale 1ns/1ps
`default_nettype none

module bmc_pixel_plot (
	input  wire                          vclk,
	input  wire                          rst_i,
	input  wire                          plot_go_i,
	input  wire bmc_video_pkg::coord_t   px_i,
	input  wire bmc_video_pkg::coord_t   py_i,
	input  wire bmc_video_pkg::coord_t   hdisp_i,
	input  wire bmc_bus_pkg::mem_adr_t   base_i,
	input  wire bmc_video_pkg::pixel_t   color_i,
	input  wire bmc_video_pkg::rop_t     rop_i,
	output logic                         busy_o,
	output bmc_bus_pkg::mem_req_t        mem_req_o,
	input  wire bmc_bus_pkg::mem_rsp_t   mem_rsp_i
);

	bmc_video_pkg::plot_state_t state;
	bmc_bus_pkg::mem_adr_t adr;
	bmc_bus_pkg::mem_dat_t word;
	bmc_video_pkg::pixel_t color_q;
	bmc_video_pkg::rop_t rop_q;
	logic [23:0] pix_ofs;

	// unknown op codes fall back to copy
	function automatic bmc_video_pkg::pixel_t rop_apply(
		input bmc_video_pkg::rop_t op,
		input bmc_video_pkg::pixel_t a,
		input bmc_video_pkg::pixel_t b
	);
		case (op)
			bmc_video_pkg::ROP_BLACK: return 16'h0000;
			bmc_video_pkg::ROP_AND:   return a & b;
			bmc_video_pkg::ROP_OR:    return a | b;
			bmc_video_pkg::ROP_XOR:   return a ^ b;
			bmc_video_pkg::ROP_WHITE: return 16'hFFFF;
			default:                  return b;
		endcase
	endfunction

	// pixel index in the frame, y * hdisp + x
	assign pix_ofs = {12'd0, py_i} * {12'd0, hdisp_i} + {12'd0, px_i};
	assign busy_o = (state != bmc_video_pkg::PLOT_IDLE);

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			state <= bmc_video_pkg::PLOT_IDLE;
		end else begin
			case (state)
				bmc_video_pkg::PLOT_IDLE:
					if (plot_go_i)
						state <= bmc_video_pkg::PLOT_READ;
				bmc_video_pkg::PLOT_READ:
					if (mem_rsp_i.ack)
						state <= bmc_video_pkg::PLOT_MODIFY;
				// bus released for this cycle
				bmc_video_pkg::PLOT_MODIFY:
					state <= bmc_video_pkg::PLOT_WRITE;
				bmc_video_pkg::PLOT_WRITE:
					if (mem_rsp_i.ack)
						state <= bmc_video_pkg::PLOT_IDLE;
			endcase
		end
	end

	// adr[1] picks the halfword, high for odd x
	always_ff @(posedge vclk) begin
		if (state == bmc_video_pkg::PLOT_IDLE && plot_go_i) begin
			adr <= base_i + {7'd0, pix_ofs, 1'b0};
			color_q <= color_i;
			rop_q <= rop_i;
		end else if (state == bmc_video_pkg::PLOT_READ && mem_rsp_i.ack) begin
			word <= mem_rsp_i.dat;
		end else if (state == bmc_video_pkg::PLOT_MODIFY) begin
			if (adr[1])
				word[31:16] <= rop_apply(rop_q, word[31:16], color_q);
			else
				word[15:0] <= rop_apply(rop_q, word[15:0], color_q);
		end
	end

	always_comb begin
		mem_req_o.cyc = (state == bmc_video_pkg::PLOT_READ) || (state == bmc_video_pkg::PLOT_WRITE);
		mem_req_o.stb = mem_req_o.cyc;
		mem_req_o.we = (state == bmc_video_pkg::PLOT_WRITE);
		mem_req_o.sel = 4'hF;
		mem_req_o.adr = {adr[31:2], 2'b00};
		mem_req_o.dat = word;
	end

endmodule

`default_nettype wire

/* design/bmc_regs.sv */
// wishbone classic register slave with plot command start and busy readback
`timescale 1ns/1ps
`default_nettype none
`include "bmc_defs.svh"

module bmc_regs (
	input  wire                         vclk,
	input  wire                         rst_i,
	input  wire                         s_cyc_i,
	input  wire                         s_stb_i,
	input  wire                         s_we_i,
	input  wire bmc_bus_pkg::mem_adr_t  s_adr_i,
	input  wire bmc_bus_pkg::mem_dat_t  s_dat_i,
	output logic                        s_ack_o,
	output bmc_bus_pkg::mem_dat_t       s_dat_o,
	output logic                        onoff_o,
	output bmc_video_pkg::coord_t       hdisp_o,
	output bmc_video_pkg::coord_t       vdisp_o,
	output bmc_bus_pkg::mem_adr_t       base_o,
	output bmc_video_pkg::coord_t       px_o,
	output bmc_video_pkg::coord_t       py_o,
	output bmc_video_pkg::pixel_t       color_o,
	output bmc_video_pkg::rop_t         rop_o,
	output logic                        plot_go_o,
	input  wire                         plot_busy_i
);

	logic access;
	logic wr;

	// new access only while ack is low, so ack stays a single pulse
	assign access = s_cyc_i & s_stb_i & ~s_ack_o;
	assign wr = access & s_we_i;

	// ====================================================================
	// ack, register writes and plot start
	// ====================================================================
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			s_ack_o <= 1'b0;
			plot_go_o <= 1'b0;
			onoff_o <= 1'b1;
			hdisp_o <= `BMC_HDISP_RESET;
			vdisp_o <= `BMC_VDISP_RESET;
			base_o <= `BMC_BASE_RESET;
			px_o <= '0;
			py_o <= '0;
			color_o <= '0;
			rop_o <= bmc_video_pkg::ROP_BLACK;
		end else begin
			s_ack_o <= access;
			// go is a one-cycle strobe
			plot_go_o <= 1'b0;
			if (wr) begin
				case (s_adr_i[4:2])
					`BMC_REG_CTRL:  onoff_o <= s_dat_i[0];
					`BMC_REG_HDISP: hdisp_o <= s_dat_i[11:0];
					`BMC_REG_VDISP: vdisp_o <= s_dat_i[11:0];
					`BMC_REG_BASE:  base_o <= s_dat_i;
					`BMC_REG_PX:    px_o <= s_dat_i[11:0];
					`BMC_REG_PY:    py_o <= s_dat_i[11:0];
					`BMC_REG_COLOR: color_o <= s_dat_i[15:0];
					`BMC_REG_PCMD: begin
						// a command while the plotter runs is dropped
						if (s_dat_i[0] && !plot_busy_i) begin
							rop_o <= bmc_video_pkg::rop_t'(s_dat_i[19:16]);
							plot_go_o <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// read data, valid during the ack cycle
	always_ff @(posedge vclk) begin
		if (access) begin
			case (s_adr_i[4:2])
				`BMC_REG_CTRL:  s_dat_o <= {31'd0, onoff_o};
				`BMC_REG_HDISP: s_dat_o <= {20'd0, hdisp_o};
				`BMC_REG_VDISP: s_dat_o <= {20'd0, vdisp_o};
				`BMC_REG_BASE:  s_dat_o <= base_o;
				`BMC_REG_PX:    s_dat_o <= {20'd0, px_o};
				`BMC_REG_PY:    s_dat_o <= {20'd0, py_o};
				`BMC_REG_COLOR: s_dat_o <= {16'd0, color_o};
				// busy in bit 0, last rop in 19:16
				`BMC_REG_PCMD:  s_dat_o <= {12'd0, rop_o, 15'd0, plot_busy_i};
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/bmc_scan_fetch.sv */
// scan line fetcher: one row of rgb565 words from memory into the line buffer
`timescale 1ns/1ps
`default_nettype none

module bmc_scan_fetch (
	input  wire                           vclk,
	input  wire                           rst_i,
	input  wire                           line_start_i,
	input  wire bmc_video_pkg::coord_t    fetch_row_i,
	input  wire                           onoff_i,
	input  wire bmc_video_pkg::coord_t    hdisp_i,
	input  wire bmc_video_pkg::coord_t    vdisp_i,
	input  wire bmc_bus_pkg::mem_adr_t    base_i,
	output bmc_bus_pkg::mem_req_t         mem_req_o,
	input  wire bmc_bus_pkg::mem_rsp_t    mem_rsp_i,
	output bmc_video_pkg::line_wr_t       line_wr_o
);

	bmc_video_pkg::fetch_state_t state;
	bmc_bus_pkg::mem_adr_t adr;
	bmc_video_pkg::line_idx_t widx;
	bmc_video_pkg::coord_t words_left;
	// pixel offset of the row start, row * hdisp
	logic [23:0] row_ofs;
	logic [12:0] hsum;
	logic fetch_en;
	logic word_done;

	assign row_ofs = {12'd0, fetch_row_i} * {12'd0, hdisp_i};
	// ceil(hdisp / 2) words per line
	assign hsum = {1'b0, hdisp_i} + 13'd1;
	assign fetch_en = onoff_i && (fetch_row_i < vdisp_i);
	assign word_done = (state == bmc_video_pkg::FETCH_WAIT) && mem_rsp_i.ack;

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			state <= bmc_video_pkg::FETCH_IDLE;
		end else begin
			case (state)
				bmc_video_pkg::FETCH_IDLE:
					if (line_start_i && fetch_en)
						state <= bmc_video_pkg::FETCH_REQ;
				// gap cycle between words, cyc is low here
				bmc_video_pkg::FETCH_REQ:
					state <= (words_left == 12'd0) ? bmc_video_pkg::FETCH_IDLE
					                               : bmc_video_pkg::FETCH_WAIT;
				bmc_video_pkg::FETCH_WAIT:
					if (mem_rsp_i.ack)
						state <= bmc_video_pkg::FETCH_REQ;
				default:
					state <= bmc_video_pkg::FETCH_IDLE;
			endcase
		end
	end

	// address, buffer index and remaining word count
	always_ff @(posedge vclk) begin
		if (state == bmc_video_pkg::FETCH_IDLE && line_start_i) begin
			adr <= base_i + {7'd0, row_ofs, 1'b0};
			widx <= '0;
			words_left <= hsum[12:1];
		end else if (word_done) begin
			adr <= adr + 32'd4;
			widx <= widx + 9'd1;
			words_left <= words_left - 12'd1;
		end
	end

	// read-only master, whole word
	always_comb begin
		mem_req_o = '0;
		mem_req_o.cyc = (state == bmc_video_pkg::FETCH_WAIT);
		mem_req_o.stb = (state == bmc_video_pkg::FETCH_WAIT);
		mem_req_o.sel = 4'hF;
		mem_req_o.adr = {adr[31:2], 2'b00};
	end

	always_comb begin
		line_wr_o.we = word_done;
		line_wr_o.idx = widx;
		line_wr_o.dat = mem_rsp_i.dat;
	end

endmodule

`default_nettype wire

/* design/bmc_video_pkg.sv */
// pixel, coordinate and colour types, raster op and FSM state enums, line write struct
`default_nettype none
`include "bmc_defs.svh"

package bmc_video_pkg;

	typedef logic [`BMC_COORD_W-1:0] coord_t;
	// rgb565 in memory, 8:8:8 on the output
	typedef logic [15:0] pixel_t;
	typedef logic [23:0] rgb_t;
	typedef logic [$clog2(`BMC_LINE_WORDS)-1:0] line_idx_t;

	// raster ops, memory is a and colour is b
	typedef enum logic [3:0] {
		ROP_BLACK = 4'd0,
		ROP_COPY  = 4'd1,
		ROP_AND   = 4'd4,
		ROP_OR    = 4'd5,
		ROP_XOR   = 4'd6,
		ROP_WHITE = 4'd15
	} rop_t;

	typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_WAIT} fetch_state_t;

	typedef enum logic [1:0] {PLOT_IDLE, PLOT_READ, PLOT_MODIFY, PLOT_WRITE} plot_state_t;

	// one word from the fetcher into the line buffer
	typedef struct packed {
		logic                  we;
		line_idx_t             idx;
		bmc_bus_pkg::mem_dat_t dat;
	} line_wr_t;

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the bitmap controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module bitmap_ctrl_tb -o bitmap_ctrl_sim
./obj_dir/bitmap_ctrl_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
	exit 0
fi
exit 1

/* verification/bitmap_ctrl_tb.sv */
// testbench top with memory model, register bus tasks, video timing, plot agent, checks and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "bmc_defs.svh"

module bitmap_ctrl_tb;

	// small screen of 16x4 visible pixels inside 20x8 of active video
	localparam int HD = 16;
	localparam int VD = 4;
	localparam int LINES = 8;
	localparam int ACTIVE = 20;
	localparam int HBLANK = 64;
	localparam int LINE_CYC = 1 + HBLANK + ACTIVE;
	localparam int FRAMES = 5;
	localparam logic [31:0] FB = 32'h0010_0000;
	localparam longint WATCHDOG_NS = 100 * (FRAMES * LINES * LINE_CYC * 2 + 4000);

	logic vclk;
	logic rst_i;
	logic s_cyc;
	logic s_stb;
	logic s_we;
	bmc_bus_pkg::mem_adr_t s_adr;
	bmc_bus_pkg::mem_dat_t s_dat;
	bmc_bus_pkg::mem_dat_t s_dat_o;
	logic s_ack_o;
	bmc_bus_pkg::mem_req_t m_req;
	bmc_bus_pkg::mem_rsp_t m_rsp = '0;
	logic hsync;
	logic vsync;
	logic blank;
	bmc_video_pkg::rgb_t rgb;

	// memory contents and the expected copy
	bmc_bus_pkg::mem_dat_t mem [int unsigned];
	bmc_bus_pkg::mem_dat_t shadow [int unsigned];
	int unsigned wait_cnt;
	integer seed = 32'h818f82c4;
	int errors = 0;
	int checks = 0;
	// expected rgb pipeline two cycles deep
	bmc_video_pkg::rgb_t cur_exp;
	bmc_video_pkg::rgb_t exp_d1;
	bmc_video_pkg::rgb_t exp_d2;
	logic chk_en = 1'b0;
	logic exp_onoff = 1'b1;
	int line_row = -1;
	int line_col = -1;

	tb_clock clock_i (.clk_o(vclk));

	bitmap_ctrl bitmap_ctrl_i (
		.vclk(vclk), .rst_i(rst_i),
		.s_cyc_i(s_cyc), .s_stb_i(s_stb), .s_we_i(s_we),
		.s_adr_i(s_adr), .s_dat_i(s_dat), .s_dat_o(s_dat_o), .s_ack_o(s_ack_o),
		.m_req_o(m_req), .m_rsp_i(m_rsp),
		.hsync_i(hsync), .vsync_i(vsync), .blank_i(blank), .rgb_o(rgb)
	);

	// a word never written takes a value derived from its whole address
	function automatic bmc_bus_pkg::mem_dat_t mem_fill(input logic [31:0] adr);
		return adr ^ {adr[15:0], adr[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function bmc_bus_pkg::mem_dat_t shadow_word(input logic [31:0] adr);
		return shadow.exists(adr[31:2]) ? shadow[adr[31:2]] : mem_fill({adr[31:2], 2'b00});
	endfunction

	// pixel (x,y) sits at base + 2*(y*hdisp + x) with odd x in the high half
	function bmc_video_pkg::pixel_t pixel_at(input int row, input int col);
		logic [31:0] a;
		bmc_bus_pkg::mem_dat_t w;
		a = FB + 2 * (row * HD + col);
		w = shadow_word(a);
		return a[1] ? w[31:16] : w[15:0];
	endfunction

	function automatic bmc_video_pkg::rgb_t expand565(input bmc_video_pkg::pixel_t p);
		return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
	endfunction

	// memory is a and colour is b
	function automatic bmc_video_pkg::pixel_t rop_result(input logic [3:0] op,
			input bmc_video_pkg::pixel_t a, input bmc_video_pkg::pixel_t b);
		case (op)
			4'd0:    return 16'h0000;
			4'd4:    return a & b;
			4'd5:    return a | b;
			4'd6:    return a ^ b;
			4'd15:   return 16'hffff;
			default: return b;
		endcase
	endfunction

	// ======================================================================
	// memory model with a random ack latency of 0 to 3 cycles
	// ======================================================================
	always @(posedge vclk) begin
		if (rst_i) begin
			m_rsp <= '0;
			wait_cnt <= 0;
		end else if (m_rsp.ack) begin
			m_rsp.ack <= 1'b0;
		end else if (m_req.cyc && m_req.stb) begin
			// every transfer is a whole word
			checks++;
			assert (m_req.sel == 4'hf) else begin
				errors++;
				$display("mismatch m_req_o.sel expected %h got %h", 4'hf, m_req.sel);
			end
			if (wait_cnt == 0) begin
				m_rsp.ack <= 1'b1;
				if (m_req.we)
					mem[m_req.adr[31:2]] = m_req.dat;
				else if (mem.exists(m_req.adr[31:2]))
					m_rsp.dat <= mem[m_req.adr[31:2]];
				else
					m_rsp.dat <= mem_fill({m_req.adr[31:2], 2'b00});
				wait_cnt <= $random(seed) & 3;
			end else begin
				wait_cnt <= wait_cnt - 1;
			end
		end
	end

	// rgb_o shows the column driven 2 clocks earlier
	always @(posedge vclk) begin
		exp_d1 <= cur_exp;
		exp_d2 <= exp_d1;
	end

	always @(negedge vclk) begin
		if (chk_en) begin
			checks++;
			assert (rgb == exp_d2) else begin
				errors++;
				$display("mismatch rgb_o expected %h got %h at %0t", exp_d2, rgb, $time);
			end
		end
	end

	// ======================================================================
	// register bus
	// ======================================================================
	task automatic bus_access(input logic we, input logic [2:0] idx,
			input bmc_bus_pkg::mem_dat_t wdat, output bmc_bus_pkg::mem_dat_t rdat);
		int waits;
		@(posedge vclk);
		s_cyc <= 1'b1;
		s_stb <= 1'b1;
		s_we <= we;
		s_adr <= {27'd0, idx, 2'b00};
		s_dat <= wdat;
		waits = 0;
		@(negedge vclk);
		while (!s_ack_o && waits < 8) begin
			@(negedge vclk);
			waits++;
		end
		// ack comes one clock after the strobe and lasts a single cycle
		checks++;
		assert (s_ack_o && waits == 1) else begin
			errors++;
			$display("register ack did not arrive one clock after the strobe");
		end
		rdat = s_dat_o;
		@(posedge vclk);
		s_cyc <= 1'b0;
		s_stb <= 1'b0;
		s_we <= 1'b0;
		@(negedge vclk);
		checks++;
		assert (!s_ack_o) else begin
			errors++;
			$display("register ack stayed high for more than one cycle");
		end
	endtask

	task automatic write_reg(input logic [2:0] idx, input bmc_bus_pkg::mem_dat_t wdat);
		bmc_bus_pkg::mem_dat_t unused;
		bus_access(1'b1, idx, wdat, unused);
	endtask

	task automatic read_reg(input logic [2:0] idx, output bmc_bus_pkg::mem_dat_t rdat);
		bus_access(1'b0, idx, 32'd0, rdat);
	endtask

	task automatic expect_reg(input logic [2:0] idx, input bmc_bus_pkg::mem_dat_t exp,
			input string name);
		bmc_bus_pkg::mem_dat_t got;
		read_reg(idx, got);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("mismatch %s expected %h got %h", name, exp, got);
		end
	endtask

	// ======================================================================
	// video timing
	// ======================================================================
	task automatic drive_video(input logic hs, input logic vs, input logic bl,
			input bmc_video_pkg::rgb_t e);
		@(posedge vclk);
		hsync <= hs;
		vsync <= vs;
		blank <= bl;
		cur_exp <= e;
	endtask

	task automatic run_frame();
		bmc_video_pkg::rgb_t snap [HD];
		drive_video(1'b0, 1'b1, 1'b1, '0);
		drive_video(1'b0, 1'b0, 1'b1, '0);
		for (int r = 0; r < LINES; r++) begin
			line_row = r;
			// the row is fetched after this hsync
			for (int c = 0; c < HD; c++)
				snap[c] = (exp_onoff && r < VD) ? expand565(pixel_at(r, c)) : '0;
			drive_video(1'b1, 1'b0, 1'b1, '0);
			repeat (HBLANK)
				drive_video(1'b0, 1'b0, 1'b1, '0);
			for (int c = 0; c < ACTIVE; c++) begin
				line_col = c;
				drive_video(1'b0, 1'b0, 1'b0, (c < HD) ? snap[c] : '0);
			end
			line_col = -1;
		end
		line_row = -1;
		repeat (3)
			drive_video(1'b0, 1'b0, 1'b1, '0);
	endtask

	// ======================================================================
	// plots issued late in a line so that each one meets the next fetch
	// ======================================================================
	task automatic plot_and_verify(input logic [3:0] op, input int x, input int y,
			input bmc_video_pkg::pixel_t color);
		logic [31:0] a;
		bmc_bus_pkg::mem_dat_t old_w;
		bmc_bus_pkg::mem_dat_t exp_w;
		bmc_bus_pkg::mem_dat_t got;
		logic [3:0] other;
		int polls;
		a = FB + 2 * (y * HD + x);
		old_w = shadow_word(a);
		exp_w = old_w;
		if (a[1])
			exp_w[31:16] = rop_result(op, old_w[31:16], color);
		else
			exp_w[15:0] = rop_result(op, old_w[15:0], color);
		other = (op == 4'd15) ? 4'd0 : 4'd15;
		write_reg(`BMC_REG_PX, x);
		write_reg(`BMC_REG_PY, y);
		write_reg(`BMC_REG_COLOR, {16'd0, color});
		write_reg(`BMC_REG_PCMD, {12'd0, op, 16'd1});
		// second command lands while busy and is dropped
		write_reg(`BMC_REG_PCMD, {12'd0, other, 16'd1});
		read_reg(`BMC_REG_PCMD, got);
		checks++;
		assert (got[19:16] == op) else begin
			errors++;
			$display("mismatch pcmd rop expected %h got %h", op, got[19:16]);
		end
		polls = 0;
		while (got[0] && polls < 200) begin
			read_reg(`BMC_REG_PCMD, got);
			polls++;
		end
		if (got[0]) begin
			errors++;
			$display("plot busy never cleared for rop %0d", op);
		end
		got = mem.exists(a[31:2]) ? mem[a[31:2]] : mem_fill({a[31:2], 2'b00});
		checks++;
		assert (got == exp_w) else begin
			errors++;
			$display("mismatch plot word at %h expected %h got %h", a, exp_w, got);
		end
		shadow[a[31:2]] = exp_w;
	endtask

	task automatic plot_series();
		logic [3:0] ops [6];
		ops = '{4'd0, 4'd1, 4'd4, 4'd5, 4'd6, 4'd15};
		for (int k = 0; k < 6; k++) begin
			@(negedge vclk);
			while (!(line_row == k && line_col == 4))
				@(negedge vclk);
			// target row is never the one being fetched
			plot_and_verify(ops[k], $random(seed) & 15, (k + 2) % VD, $random(seed));
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed");
		$display("Regression failed");
		$finish;
	end

	// ======================================================================
	// main sequence
	// ======================================================================
	initial begin
		rst_i = 1'b1;
		s_cyc = 1'b0;
		s_stb = 1'b0;
		s_we = 1'b0;
		s_adr = '0;
		s_dat = '0;
		hsync = 1'b0;
		vsync = 1'b0;
		blank = 1'b1;
		cur_exp = '0;
		repeat (10)
			@(posedge vclk);
		rst_i <= 1'b0;
		@(negedge vclk);
		checks++;
		assert (!s_ack_o && !m_req.cyc && !m_req.stb && !m_req.we && rgb == '0) else begin
			errors++;
			$display("mismatch after reset expected 0 got s_ack_o %h cyc %h stb %h we %h rgb_o %h",
				s_ack_o, m_req.cyc, m_req.stb, m_req.we, rgb);
		end
		chk_en = 1'b1;
		for (int i = 0; i < VD * HD / 2; i++) begin
			mem[(FB >> 2) + i] = $random(seed);
			shadow[(FB >> 2) + i] = mem[(FB >> 2) + i];
		end

		// reset values and then readback of every register
		expect_reg(`BMC_REG_CTRL, 32'd1, "ctrl");
		expect_reg(`BMC_REG_HDISP, 32'd320, "hdisp");
		expect_reg(`BMC_REG_VDISP, 32'd240, "vdisp");
		expect_reg(`BMC_REG_BASE, 32'h0020_0000, "base");
		expect_reg(`BMC_REG_PX, 32'd0, "px");
		expect_reg(`BMC_REG_PY, 32'd0, "py");
		expect_reg(`BMC_REG_COLOR, 32'd0, "color");
		expect_reg(`BMC_REG_PCMD, 32'd0, "pcmd");
		write_reg(`BMC_REG_CTRL, 32'd0);
		write_reg(`BMC_REG_HDISP, 32'h5a3);
		write_reg(`BMC_REG_VDISP, 32'h1c7);
		write_reg(`BMC_REG_BASE, 32'hdead_beec);
		write_reg(`BMC_REG_PX, 32'h123);
		write_reg(`BMC_REG_PY, 32'h456);
		write_reg(`BMC_REG_COLOR, 32'hbeef);
		expect_reg(`BMC_REG_CTRL, 32'd0, "ctrl");
		expect_reg(`BMC_REG_HDISP, 32'h5a3, "hdisp");
		expect_reg(`BMC_REG_VDISP, 32'h1c7, "vdisp");
		expect_reg(`BMC_REG_BASE, 32'hdead_beec, "base");
		expect_reg(`BMC_REG_PX, 32'h123, "px");
		expect_reg(`BMC_REG_PY, 32'h456, "py");
		expect_reg(`BMC_REG_COLOR, 32'hbeef, "color");

		// display geometry for the video tests
		write_reg(`BMC_REG_HDISP, HD);
		write_reg(`BMC_REG_VDISP, VD);
		write_reg(`BMC_REG_BASE, FB);
		write_reg(`BMC_REG_CTRL, 32'd1);
		run_frame();
		run_frame();
		write_reg(`BMC_REG_CTRL, 32'd0);
		exp_onoff = 1'b0;
		run_frame();
		write_reg(`BMC_REG_CTRL, 32'd1);
		exp_onoff = 1'b1;
		fork
			run_frame();
			plot_series();
		join
		run_frame();

		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// testbench clock generator, 100 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk_o
);

	initial clk_o = 1'b0;

	// half period 50 ns
	always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire
